/* rtl/vtb_pkg.sv */
package vtb_pkg;

	// AXI4-Lite master to slave
	typedef struct packed {
		logic [7:0]		awaddr;
		logic			awvalid;
		logic [31:0]	wdata;
		logic [3:0]		wstrb;		// Byte lanes
		logic			wvalid;
		logic			bready;
		logic [7:0]		araddr;
		logic			arvalid;
		logic			rready;
	} axil_req_t;

	// AXI4-Lite slave to master
	typedef struct packed {
		logic			awready;
		logic			wready;
		logic			bvalid;
		logic [1:0]		bresp;
		logic			arready;
		logic			rvalid;
		logic [31:0]	rdata;
		logic [1:0]		rresp;
	} axil_rsp_t;

	// Held control registers
	typedef struct packed {
		logic			tg_run;		// Timing generator run
		logic			tpg_run;	// Pattern generator run
		logic			tpg_ramp;	// Ramp instead of bars
		logic [15:0]	h_act;		// Active clocks per line
		logic [15:0]	h_tot;		// Total clocks per line
		logic [15:0]	v_act;		// Active lines
		logic [15:0]	v_tot;		// Total lines
	} vtb_ctl_t;

	typedef struct packed {
		logic	vs;
		logic	hs;
		logic	de;
	} vtb_sync_t;

	// Lines in the upper half, as REG_MON reads it
	typedef struct packed {
		logic [15:0]	lin;	// Lines per frame
		logic [15:0]	pix;	// Beats per line
	} vtb_mon_t;

	localparam logic [7:0] REG_CTL		= 8'h00;
	localparam logic [7:0] REG_H_ACT	= 8'h04;
	localparam logic [7:0] REG_H_TOT	= 8'h08;
	localparam logic [7:0] REG_V_ACT	= 8'h0C;
	localparam logic [7:0] REG_V_TOT	= 8'h10;
	localparam logic [7:0] REG_MON		= 8'h14;	// Read only

	localparam int CTL_TG_RUN	= 0;
	localparam int CTL_TPG_RUN	= 1;
	localparam int CTL_TPG_RAMP	= 2;

	localparam logic [1:0] AXI_OKAY = 2'b00;

	localparam int HS_OFS		= 2;	// Clocks from end of active to hsync
	localparam int HS_WIDTH		= 4;
	localparam int VS_LINE_OFS	= 1;	// Lines from end of active to vsync line
	localparam int BAR_SHIFT	= 4;	// 16 pixel bars

endpackage

/* rtl/vtb_ctl.sv */
`timescale 1ns/1ps

module vtb_ctl
	import vtb_pkg::*;
(
	input  logic		rst_from_vid_rst,	// Clock
	input  logic		VID_CLK_IN,			// Reset
	input  axil_req_t	axil_req,			// Host side
	output axil_rsp_t	axil_rsp,
	output vtb_ctl_t	ctl,				// Held registers
	input  vtb_mon_t	mon					// Monitor results
);

	logic			wr_rdy;		// Shared awready and wready pulse
	logic			bvalid;
	logic			rd_rdy;		// arready pulse
	logic			rvalid;
	logic [31:0]	rdata;
	logic [31:0]	rd_mux;
	logic			wr_hs;
	logic			rd_hs;

	// Byte lane update of a 16 bit register
	function automatic logic [15:0] wr16(
		input logic [15:0]	cur,
		input logic [31:0]	dat,
		input logic [1:0]	strb
	);
		logic [15:0] res;
		res = cur;
		if (strb[0])
			res[7:0] = dat[7:0];
		if (strb[1])
			res[15:8] = dat[15:8];
		return res;
	endfunction

	assign wr_hs = wr_rdy && axil_req.awvalid && axil_req.wvalid;
	assign rd_hs = rd_rdy && axil_req.arvalid;

	// Write address, data and response
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			wr_rdy <= 1'b0;
			bvalid <= 1'b0;
		end
		else
		begin
			// Single cycle pulse, blocked while a response waits
			wr_rdy <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_rdy;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (axil_req.bready)
				bvalid <= 1'b0;		// Response taken
		end
	end

	// Register file
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
			ctl <= '0;
		else if (wr_hs)
		begin
			case (axil_req.awaddr)
				REG_CTL:
				begin
					if (axil_req.wstrb[0])
					begin
						ctl.tg_run   <= axil_req.wdata[CTL_TG_RUN];
						ctl.tpg_run  <= axil_req.wdata[CTL_TPG_RUN];
						ctl.tpg_ramp <= axil_req.wdata[CTL_TPG_RAMP];
					end
				end
				REG_H_ACT:	ctl.h_act <= wr16(ctl.h_act, axil_req.wdata, axil_req.wstrb[1:0]);
				REG_H_TOT:	ctl.h_tot <= wr16(ctl.h_tot, axil_req.wdata, axil_req.wstrb[1:0]);
				REG_V_ACT:	ctl.v_act <= wr16(ctl.v_act, axil_req.wdata, axil_req.wstrb[1:0]);
				REG_V_TOT:	ctl.v_tot <= wr16(ctl.v_tot, axil_req.wdata, axil_req.wstrb[1:0]);
				default: ;	// Monitor and holes ignore writes
			endcase
		end
	end

	// Read select
	always_comb
	begin
		rd_mux = '0;	// Holes read zero
		case (axil_req.araddr)
			REG_CTL:
			begin
				rd_mux[CTL_TG_RUN]   = ctl.tg_run;
				rd_mux[CTL_TPG_RUN]  = ctl.tpg_run;
				rd_mux[CTL_TPG_RAMP] = ctl.tpg_ramp;
			end
			REG_H_ACT:	rd_mux[15:0] = ctl.h_act;
			REG_H_TOT:	rd_mux[15:0] = ctl.h_tot;
			REG_V_ACT:	rd_mux[15:0] = ctl.v_act;
			REG_V_TOT:	rd_mux[15:0] = ctl.v_tot;
			REG_MON:	rd_mux = mon;	// Lines high, pixels low
			default: ;
		endcase
	end

	// Read address and data handshake
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			rd_rdy <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			rd_rdy <= axil_req.arvalid && !rvalid && !rd_rdy;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	// Read data
	always_ff @(posedge rst_from_vid_rst)
	begin
		if (rd_hs)
			rdata <= rd_mux;
	end

	always_comb
	begin
		axil_rsp         = '0;
		axil_rsp.awready = wr_rdy;
		axil_rsp.wready  = wr_rdy;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = AXI_OKAY;
		axil_rsp.arready = rd_rdy;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = AXI_OKAY;
	end

	// Responses stay up until the host takes them
	a_bvalid_hold: assert property (@(posedge rst_from_vid_rst) disable iff (VID_CLK_IN)
		bvalid && !axil_req.bready |=> bvalid)
		else $error("bvalid dropped without bready");

	a_rvalid_hold: assert property (@(posedge rst_from_vid_rst) disable iff (VID_CLK_IN)
		rvalid && !axil_req.rready |=> rvalid && $stable(rdata))
		else $error("rvalid or rdata changed without rready");

endmodule

/* rtl/vtb_tg.sv */
`timescale 1ns/1ps

module vtb_tg
	import vtb_pkg::*;
(
	input  logic		rst_from_vid_rst,	// Clock
	input  logic		VID_CLK_IN,			// Reset
	input  vtb_ctl_t	ctl,				// Raster and run
	output vtb_sync_t	sync				// Registered timing
);

	logic [15:0]	h_cnt;		// Clock in line
	logic [15:0]	v_cnt;		// Line in frame
	logic			h_end;
	logic			v_end;
	logic [16:0]	hs_beg;		// First hsync clock
	logic [16:0]	hs_end;		// First clock after hsync
	logic [16:0]	vs_lin;		// Vsync line

	// Greater or equal so a shrunk raster still wraps
	assign h_end = (h_cnt >= ctl.h_tot - 16'd1);
	assign v_end = (v_cnt >= ctl.v_tot - 16'd1);

	// One bit wider against overflow near the top of the range
	assign hs_beg = {1'b0, ctl.h_act} + 17'(HS_OFS);
	assign hs_end = hs_beg + 17'(HS_WIDTH);
	assign vs_lin = {1'b0, ctl.v_act} + 17'(VS_LINE_OFS);

	// Counters
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (!ctl.tg_run)
		begin
			h_cnt <= '0;	// Parked at frame start
			v_cnt <= '0;
		end
		else
		begin
			if (h_end)
			begin
				h_cnt <= '0;
				if (v_end)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 16'd1;
			end
			else
				h_cnt <= h_cnt + 16'd1;
		end
	end

	// Sync decode, one cycle behind the counters
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
			sync <= '0;
		else
		begin
			sync.de <= ctl.tg_run && (h_cnt < ctl.h_act) && (v_cnt < ctl.v_act);
			sync.hs <= ctl.tg_run && ({1'b0, h_cnt} >= hs_beg) && ({1'b0, h_cnt} < hs_end);
			sync.vs <= ctl.tg_run && ({1'b0, v_cnt} == vs_lin);	// Whole line
		end
	end

	// Counter inside the programmed line length
	a_h_range: assert property (@(posedge rst_from_vid_rst) disable iff (VID_CLK_IN)
		ctl.tg_run && $stable(ctl.h_tot) |-> h_cnt < ctl.h_tot)
		else $error("h_cnt outside h_tot");

endmodule

/* rtl/vtb_tpg.sv */
`timescale 1ns/1ps

module vtb_tpg
	import vtb_pkg::*;
#(
	parameter int P_PPC = 2,	// Pixels per clock
	parameter int P_BPC = 8		// Bits per component
)
(
	input  logic						rst_from_vid_rst,	// Clock
	input  logic						VID_CLK_IN,			// Reset
	input  vtb_ctl_t					ctl,
	input  vtb_sync_t					sync_in,			// From timing generator
	output vtb_sync_t					sync_out,			// One stage later
	output logic [P_PPC*P_BPC-1:0]		vid_r,
	output logic [P_PPC*P_BPC-1:0]		vid_g,
	output logic [P_PPC*P_BPC-1:0]		vid_b
);

	logic [15:0]				x_cnt;	// Active clocks so far in line
	logic [31:0]				idx;	// Pixel index
	logic [2:0]					bar;
	logic [P_PPC*P_BPC-1:0]		pix_r;
	logic [P_PPC*P_BPC-1:0]		pix_g;
	logic [P_PPC*P_BPC-1:0]		pix_b;

	// Pixels of the current clock
	always_comb
	begin
		pix_r = '0;		// Black when stopped or blanked
		pix_g = '0;
		pix_b = '0;
		idx   = '0;
		bar   = '0;
		for (int k = 0; k < P_PPC; k++)
		begin
			idx = 32'(x_cnt) * P_PPC + k;
			bar = 3'(idx >> BAR_SHIFT);
			if (ctl.tpg_run && sync_in.de)
			begin
				if (ctl.tpg_ramp)
				begin
					pix_r[k*P_BPC +: P_BPC] = idx[P_BPC-1:0];	// Wraps at full scale
					pix_g[k*P_BPC +: P_BPC] = idx[P_BPC-1:0];
					pix_b[k*P_BPC +: P_BPC] = idx[P_BPC-1:0];
				end
				else
				begin
					// White yellow cyan green magenta red blue black
					pix_r[k*P_BPC +: P_BPC] = {P_BPC{~bar[1]}};
					pix_g[k*P_BPC +: P_BPC] = {P_BPC{~bar[2]}};
					pix_b[k*P_BPC +: P_BPC] = {P_BPC{~bar[0]}};
				end
			end
		end
	end

	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			x_cnt    <= '0;
			sync_out <= '0;
			vid_r    <= '0;
			vid_g    <= '0;
			vid_b    <= '0;
		end
		else
		begin
			if (sync_in.de)
				x_cnt <= x_cnt + 16'd1;
			else
				x_cnt <= '0;	// Restart in blanking
			sync_out <= sync_in;
			vid_r    <= pix_r;	// Aligned with delayed de
			vid_g    <= pix_g;
			vid_b    <= pix_b;
		end
	end

	a_blank_black: assert property (@(posedge rst_from_vid_rst) disable iff (VID_CLK_IN)
		!sync_out.de |-> (vid_r == '0) && (vid_g == '0) && (vid_b == '0))
		else $error("Colour outside active video");

endmodule

/* rtl/vtb_mon.sv */
`timescale 1ns/1ps

module vtb_mon
	import vtb_pkg::*;
(
	input  logic		rst_from_vid_rst,	// Clock
	input  logic		VID_CLK_IN,			// Reset
	input  logic		sof,				// Start of frame
	input  logic		eol,				// End of line
	input  logic		vld,				// Beat valid
	output vtb_mon_t	mon					// Latched results
);

	logic [15:0]	pix_cnt;	// Beats in current line
	logic [15:0]	lin_cnt;	// Lines since last sof

	// Pixels per line
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			pix_cnt <= '0;
			mon.pix <= '0;
		end
		else if (vld)
		begin
			if (eol)
			begin
				mon.pix <= pix_cnt + 16'd1;		// Including the eol beat
				pix_cnt <= '0;
			end
			else
				pix_cnt <= pix_cnt + 16'd1;
		end
	end

	// Lines per frame
	always_ff @(posedge rst_from_vid_rst or posedge VID_CLK_IN)
	begin
		if (VID_CLK_IN)
		begin
			lin_cnt <= '0;
			mon.lin <= '0;
		end
		else if (vld)
		begin
			if (sof)
			begin
				mon.lin <= lin_cnt;		// Finished frame
				lin_cnt <= eol ? 16'd1 : 16'd0;	// Single beat line counts too
			end
			else if (eol)
				lin_cnt <= lin_cnt + 16'd1;
		end
	end

endmodule

/* rtl/vtb_top.sv */
`timescale 1ns/1ps

module vtb_top
	import vtb_pkg::*;
#(
	parameter int P_PPC = 2,	// Pixels per clock
	parameter int P_BPC = 8		// Bits per component
)
(
	input  logic						rst_from_vid_rst,	// Video clock
	input  logic						VID_CLK_IN,			// Async reset

	// Host
	input  axil_req_t					axil_req,
	output axil_rsp_t					axil_rsp,

	// Stream in
	input  logic						axis_sof,
	input  logic						axis_eol,
	input  logic						axis_vld,
	input  logic [3*P_PPC*P_BPC-1:0]	axis_dat,			// Not inspected

	// Video out
	output vtb_sync_t					vid_sync,
	output logic [P_PPC*P_BPC-1:0]		vid_r,
	output logic [P_PPC*P_BPC-1:0]		vid_g,
	output logic [P_PPC*P_BPC-1:0]		vid_b
);

	vtb_ctl_t	ctl_from_ctl;	// Held registers
	vtb_sync_t	sync_from_tg;
	vtb_mon_t	res_from_mon;	// Stream measurement

	vtb_ctl i_ctl (
		.rst_from_vid_rst	(rst_from_vid_rst),
		.VID_CLK_IN			(VID_CLK_IN),
		.axil_req			(axil_req),
		.axil_rsp			(axil_rsp),
		.ctl				(ctl_from_ctl),
		.mon				(res_from_mon)
	);

	vtb_tg i_tg (
		.rst_from_vid_rst	(rst_from_vid_rst),
		.VID_CLK_IN			(VID_CLK_IN),
		.ctl				(ctl_from_ctl),
		.sync				(sync_from_tg)		// Counters plus one
	);

	// Always on the output, black when stopped
	vtb_tpg #(
		.P_PPC				(P_PPC),
		.P_BPC				(P_BPC)
	) i_tpg (
		.rst_from_vid_rst	(rst_from_vid_rst),
		.VID_CLK_IN			(VID_CLK_IN),
		.ctl				(ctl_from_ctl),
		.sync_in			(sync_from_tg),
		.sync_out			(vid_sync),			// Counters plus two
		.vid_r				(vid_r),
		.vid_g				(vid_g),
		.vid_b				(vid_b)
	);

	vtb_mon i_mon (
		.rst_from_vid_rst	(rst_from_vid_rst),
		.VID_CLK_IN			(VID_CLK_IN),
		.sof				(axis_sof),
		.eol				(axis_eol),
		.vld				(axis_vld),
		.mon				(res_from_mon)
	);

endmodule

/* sim/vtb_tb.sv */
`timescale 1ns/1ps

module vtb_tb
	import vtb_pkg::*;
();

	localparam int P_PPC = 2;
	localparam int P_BPC = 8;
	localparam int W     = P_PPC * P_BPC;

	typedef struct packed {
		logic [15:0]	h_act;
		logic [15:0]	h_tot;
		logic [15:0]	v_act;
		logic [15:0]	v_tot;
		logic			ramp;
		logic [15:0]	len;	// Stream beats per line
		logic [15:0]	lines;	// Stream lines per frame
	} case_t;

	localparam int N_CASES = 4;
	localparam case_t CASES [N_CASES] = '{
		'{16'd64,  16'd76,  16'd3, 16'd6, 1'b0, 16'd5,  16'd3},	// All eight bars
		'{16'd20,  16'd30,  16'd2, 16'd5, 1'b1, 16'd7,  16'd4},
		'{16'd140, 16'd150, 16'd2, 16'd5, 1'b1, 16'd3,  16'd6},	// Ramp wraps past 255
		'{16'd10,  16'd18,  16'd4, 16'd7, 1'b0, 16'd12, 16'd2}	// Tight blanking
	};

	logic			vid_clk = 1'b0;
	logic			vid_rst = 1'b1;
	axil_req_t		req;
	axil_rsp_t		rsp;
	logic			axis_sof;
	logic			axis_eol;
	logic			axis_vld;
	logic [3*W-1:0]	axis_dat;
	vtb_sync_t		vid_sync;
	logic [W-1:0]	vid_r;
	logic [W-1:0]	vid_g;
	logic [W-1:0]	vid_b;
	logic [31:0]	shadow [8];		// Expected readback per address
	int				seed = 85982;
	int				cycles;
	int				err_reg;
	int				err_pix;
	int				err_mon;
	int				err_tim;

	always #50 vid_clk = ~vid_clk;

	vtb_top #(
		.P_PPC				(P_PPC),
		.P_BPC				(P_BPC)
	) i_vtb_top (
		.rst_from_vid_rst	(vid_clk),
		.VID_CLK_IN			(vid_rst),
		.axil_req			(req),
		.axil_rsp			(rsp),
		.axis_sof			(axis_sof),
		.axis_eol			(axis_eol),
		.axis_vld			(axis_vld),
		.axis_dat			(axis_dat),
		.vid_sync			(vid_sync),
		.vid_r				(vid_r),
		.vid_g				(vid_g),
		.vid_b				(vid_b)
	);

	// Three frames per entry, stream with worst case gaps, plus slack
	function automatic int run_limit();
		int n;
		n = 2000;
		for (int i = 0; i < N_CASES; i++)
			n += 3 * int'(CASES[i].h_tot) * int'(CASES[i].v_tot)
				+ 6 * int'(CASES[i].len) * int'(CASES[i].lines) + 1;
		return n;
	endfunction

	task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			err_reg++;
			$display("ERROR %s got 0x%08h exp 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_pix(input int pos, input logic [W-1:0] got_r, got_g, got_b,
		input logic [W-1:0] exp_r, exp_g, exp_b);
		if (got_r !== exp_r || got_g !== exp_g || got_b !== exp_b)
		begin
			err_pix++;
			$display("ERROR vid_r/g/b at clock %0d got 0x%h/%h/%h exp 0x%h/%h/%h",
				pos, got_r, got_g, got_b, exp_r, exp_g, exp_b);
		end
	endtask

	task automatic check_mon(input vtb_mon_t got, input vtb_mon_t exp);
		if (got !== exp)
		begin
			err_mon++;
			$display("ERROR REG_MON got lin 0x%04h pix 0x%04h exp lin 0x%04h pix 0x%04h",
				got.lin, got.pix, exp.lin, exp.pix);
		end
	endtask

	task automatic check_cnt(input string name, input int got, input int exp);
		if (got != exp)
		begin
			err_tim++;
			$display("ERROR %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(negedge vid_clk);
		req.awaddr  = addr;
		req.wdata   = data;
		req.wstrb   = strb;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		@(negedge vid_clk);
		while (!rsp.awready)
			@(negedge vid_clk);
		check_reg("wready", {31'h0, rsp.wready}, 32'h1);	// Pulses with awready
		@(negedge vid_clk);		// Handshake edge passed
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		while (!rsp.bvalid)
			@(negedge vid_clk);
		check_reg("bresp", {30'h0, rsp.bresp}, {30'h0, AXI_OKAY});
		req.bready = 1'b1;
		@(negedge vid_clk);
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		@(negedge vid_clk);
		req.araddr  = addr;
		req.arvalid = 1'b1;
		@(negedge vid_clk);
		while (!rsp.arready)
			@(negedge vid_clk);
		@(negedge vid_clk);
		req.arvalid = 1'b0;
		while (!rsp.rvalid)
			@(negedge vid_clk);
		data = rsp.rdata;
		check_reg("rresp", {30'h0, rsp.rresp}, {30'h0, AXI_OKAY});
		req.rready = 1'b1;
		@(negedge vid_clk);
		req.rready = 1'b0;
	endtask

	// Bits each register really holds
	function automatic logic [31:0] reg_mask(input logic [7:0] addr);
		case (addr)
			REG_CTL:	return 32'h0000_0007;	// Run, pattern run, ramp
			REG_H_ACT, REG_H_TOT, REG_V_ACT, REG_V_TOT:
				return 32'h0000_FFFF;
			default:	return 32'h0;	// Monitor and holes
		endcase
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] cur, dat,
		input logic [3:0] strb, input logic [31:0] mask);
		logic [31:0] res;
		res = cur;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				res[8*b +: 8] = dat[8*b +: 8];
		return (res & mask) | (cur & ~mask);
	endfunction

	task automatic reg_access(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] got;
		axi_write(addr, data, strb);
		shadow[addr[4:2]] = merge_bytes(shadow[addr[4:2]], data, strb, reg_mask(addr));
		axi_read(addr, got);
		check_reg($sformatf("rdata at 0x%02h", addr), got, shadow[addr[4:2]]);
	endtask

	// Bar order white yellow cyan green magenta red blue black, as {r, g, b}
	function automatic logic [2:0] bar_rgb(input int bar);
		case (bar)
			0:			return 3'b111;
			1:			return 3'b110;
			2:			return 3'b011;
			3:			return 3'b010;
			4:			return 3'b101;
			5:			return 3'b100;
			6:			return 3'b001;
			default:	return 3'b000;
		endcase
	endfunction

	// One component (0 r, 1 g, 2 b) of all pixels at position x
	function automatic logic [W-1:0] exp_comp(input int x, input logic ramp, input logic on,
		input int comp);
		logic [W-1:0]	v;
		logic [2:0]		rgb;
		int				idx;
		v = '0;
		for (int k = 0; k < P_PPC; k++)
		begin
			idx = x * P_PPC + k;
			rgb = bar_rgb((idx >> BAR_SHIFT) % 8);
			if (on && ramp)
				v[k*P_BPC +: P_BPC] = P_BPC'(idx % (1 << P_BPC));
			else if (on)
				v[k*P_BPC +: P_BPC] = {P_BPC{rgb[2'(2 - comp)]}};
		end
		return v;
	endfunction

	// Starts on the first active clock of a frame
	task automatic measure_frame(input case_t tc, input logic pat_on);
		int		h_tot;
		int		de_cnt;
		int		hs_cnt;
		int		de_lines;
		int		vs_cnt;
		int		vs_rise;
		int		hs_last;
		int		x;
		logic	prev_hs;
		logic	prev_vs;
		logic	on;
		h_tot    = int'(tc.h_tot);
		x        = 0;
		de_cnt   = 0;
		hs_cnt   = 0;
		de_lines = 0;
		vs_cnt   = 0;
		vs_rise  = 0;
		hs_last  = -1;	// No hsync seen yet
		prev_hs  = 1'b0;
		prev_vs  = 1'b0;
		for (int i = 0; i < h_tot * int'(tc.v_tot); i++)
		begin
			on = pat_on && vid_sync.de;
			check_pix(i, vid_r, vid_g, vid_b, exp_comp(x, tc.ramp, on, 0),
				exp_comp(x, tc.ramp, on, 1), exp_comp(x, tc.ramp, on, 2));
			if (vid_sync.de)
			begin
				de_cnt++;
				x++;
			end
			else
				x = 0;		// New line restarts the pixel index
			if (vid_sync.hs && !prev_hs)
			begin
				if (hs_last >= 0)
					check_cnt("hsync period", i - hs_last, h_tot);
				hs_last = i;
			end
			if (vid_sync.hs)
				hs_cnt++;
			if (vid_sync.vs)
				vs_cnt++;
			if (vid_sync.vs && !prev_vs)
				vs_rise++;
			prev_hs = vid_sync.hs;
			prev_vs = vid_sync.vs;
			if (i % h_tot == h_tot - 1)
			begin
				if (de_cnt != 0)
				begin
					de_lines++;
					check_cnt("de clocks per line", de_cnt, int'(tc.h_act));
				end
				check_cnt("hsync clocks per line", hs_cnt, HS_WIDTH);
				de_cnt = 0;
				hs_cnt = 0;
			end
			@(negedge vid_clk);
		end
		check_cnt("de lines per frame", de_lines, int'(tc.v_act));
		check_cnt("vsync clocks per frame", vs_cnt, h_tot);	// Exactly one line
		check_cnt("vsync pulses per frame", vs_rise, 1);
	endtask

	task automatic check_halt(input int n);
		int hits;
		hits = 0;
		repeat (3)
			@(negedge vid_clk);		// Drain ctl, counters and pattern stage
		repeat (n)
		begin
			if (vid_sync.de || vid_sync.hs || vid_sync.vs)
				hits++;
			@(negedge vid_clk);
		end
		check_cnt("vid_sync clocks while halted", hits, 0);
	endtask

	// Two frames, then a lone sof beat to latch the second frame's lines
	task automatic drive_stream(input int len, input int lines);
		int gap;
		for (int f = 0; f < 2; f++)
			for (int l = 0; l < lines; l++)
				for (int p = 0; p < len; p++)
				begin
					gap      = $unsigned($random(seed)) % 3;
					axis_vld = 1'b0;
					repeat (gap)
						@(negedge vid_clk);
					axis_vld = 1'b1;
					axis_sof = (l == 0 && p == 0);
					axis_eol = (p == len - 1);
					axis_dat = (3*W)'({$random(seed), $random(seed)});
					@(negedge vid_clk);
				end
		axis_sof = 1'b1;
		axis_eol = 1'b0;
		@(negedge vid_clk);
		axis_vld = 1'b0;
		axis_sof = 1'b0;
		@(negedge vid_clk);		// Latch visible
	endtask

	// Watchdog
	initial
	begin
		cycles = 0;
		while (cycles < run_limit())
		begin
			@(posedge vid_clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		case_t			tc;
		logic [31:0]	rd;
		logic [31:0]	ctl_run;
		logic [31:0]	ctl_stop;
		vtb_mon_t		exp_mon;
		int				total;
		req      = '0;
		axis_sof = 1'b0;
		axis_eol = 1'b0;
		axis_vld = 1'b0;
		axis_dat = '0;
		foreach (shadow[i])
			shadow[i] = '0;
		repeat (5)
			@(negedge vid_clk);
		vid_rst = 1'b0;

		// Byte strobes, holes and the read only monitor
		reg_access(REG_H_ACT, 32'hDEAD_1234, 4'hF);
		reg_access(REG_H_ACT, 32'h0000_AB00, 4'h2);		// Upper byte only
		reg_access(REG_H_TOT, 32'h5A5A_00CD, 4'h1);
		reg_access(REG_V_ACT, 32'hFFFF_FFFF, 4'hC);		// Lanes with no storage
		reg_access(REG_V_TOT, 32'h0000_0F0F, 4'h3);
		reg_access(REG_CTL,   32'h0000_0006, 4'h1);		// Pattern bits, timing stays off
		reg_access(REG_CTL,   32'h0000_0000, 4'h0);
		reg_access(REG_CTL,   32'hFFFF_FFF8, 4'hF);
		reg_access(8'h18,     32'hFFFF_FFFF, 4'hF);
		reg_access(REG_MON,   32'hFFFF_FFFF, 4'hF);

		for (int i = 0; i < N_CASES; i++)
		begin
			tc = CASES[i];
			ctl_run = 32'h0;
			ctl_run[CTL_TG_RUN]   = 1'b1;
			ctl_run[CTL_TPG_RUN]  = 1'b1;
			ctl_run[CTL_TPG_RAMP] = tc.ramp;
			ctl_stop = ctl_run;
			ctl_stop[CTL_TPG_RUN] = 1'b0;
			axi_write(REG_CTL, 32'h0, 4'hF);
			check_halt(2 * int'(tc.h_tot));
			axi_write(REG_H_ACT, {16'h0, tc.h_act}, 4'hF);
			axi_write(REG_H_TOT, {16'h0, tc.h_tot}, 4'hF);
			axi_write(REG_V_ACT, {16'h0, tc.v_act}, 4'hF);
			axi_write(REG_V_TOT, {16'h0, tc.v_tot}, 4'hF);
			axi_write(REG_CTL, ctl_run, 4'hF);
			while (!vid_sync.de)
				@(negedge vid_clk);		// Counters start at frame origin
			measure_frame(tc, 1'b1);
			axi_write(REG_CTL, ctl_stop, 4'hF);
			while (!vid_sync.vs)
				@(negedge vid_clk);
			while (vid_sync.vs)
				@(negedge vid_clk);
			while (!vid_sync.de)
				@(negedge vid_clk);		// Next frame origin
			measure_frame(tc, 1'b0);
			drive_stream(int'(tc.len), int'(tc.lines));
			axi_read(REG_MON, rd);
			exp_mon.lin = tc.lines;
			exp_mon.pix = tc.len;
			check_mon(vtb_mon_t'(rd), exp_mon);
		end

		total = err_reg + err_pix + err_mon + err_tim;
		$display("Errors: register %0d, pixel %0d, monitor %0d, timing %0d, total %0d",
			err_reg, err_pix, err_mon, err_tim, total);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* sim.f */
rtl/vtb_pkg.sv
rtl/vtb_ctl.sv
rtl/vtb_tg.sv
rtl/vtb_tpg.sv
rtl/vtb_mon.sv
rtl/vtb_top.sv
sim/vtb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the video toolbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module vtb_tb \
	-Mdir "$BUILD_DIR" -o vtb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/vtb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
